//--- hw/link_pkg.sv
`default_nettype none

package link_pkg;

   typedef logic [31:0] ll_word_t;
   typedef logic [3:0]  ll_rem_t;
   // index into the eight header or trailer words
   typedef logic [2:0]  hdr_cnt_t;

   parameter int       HDR_WORDS    = 8;
   parameter hdr_cnt_t HDR_LAST     = hdr_cnt_t'(HDR_WORDS - 1);
   parameter hdr_cnt_t HDR_FLAG_IDX = 3'd4;
   parameter hdr_cnt_t HDR_LEN_IDX  = 3'd5;
   parameter hdr_cnt_t HDR_TASK_IDX = 3'd6;

   // valid bytes sit in the high end of the word
   function automatic ll_word_t rem_mask(input ll_rem_t rem);
      case (rem)
         4'b0001: rem_mask = 32'hffff_ff00;
         4'b0011: rem_mask = 32'hffff_0000;
         4'b0111: rem_mask = 32'hff00_0000;
         default: rem_mask = 32'hffff_ffff;
      endcase
   endfunction

   function automatic logic [2:0] rem_bytes(input ll_rem_t rem);
      case (rem)
         4'b0001: rem_bytes = 3'd3;
         4'b0011: rem_bytes = 3'd2;
         4'b0111: rem_bytes = 3'd1;
         default: rem_bytes = 3'd4;
      endcase
   endfunction

endpackage

`default_nettype wire

//--- hw/comp_pkg.sv
`default_nettype none

package comp_pkg;

   typedef logic [2:0]  op_flags_t;
   typedef logic [31:0] byte_len_t;
   typedef logic [9:0]  task_idx_t;
   typedef logic [9:0]  dcr_addr_t;

   // DCR register map
   parameter dcr_addr_t DCR_CTRL  = 10'd0;
   parameter dcr_addr_t DCR_TASK  = 10'd2;
   parameter dcr_addr_t DCR_COUNT = 10'd4;
   parameter dcr_addr_t DCR_LEN   = 10'd5;
   parameter dcr_addr_t DCR_ID0   = 10'd6;
   parameter dcr_addr_t DCR_ID1   = 10'd7;

   // write of this bit at DCR_CTRL clears the engine
   parameter int CTRL_CLEAR_BIT = 31;

   parameter logic [31:0] ID0_VALUE = 32'h1006_0402;
   parameter logic [31:0] ID1_VALUE = 32'haa55_55aa;

endpackage

`default_nettype wire

//--- hw/ll_tx_parser.sv
`timescale 1ns/1ps
`default_nettype none

module ll_tx_parser (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 eng_clear_i,
   input  wire link_pkg::ll_word_t   tx_d_i,
   input  wire link_pkg::ll_rem_t    tx_rem_i,
   input  wire logic                 tx_sof_n_i,
   input  wire logic                 tx_eop_n_i,
   input  wire logic                 tx_eof_n_i,
   input  wire logic                 tx_src_rdy_n_i,
   output logic                      tx_dst_rdy_n_o,
   input  wire logic                 fifo_full_i,
   input  wire logic                 frame_done_i,
   output logic                      push_o,
   output link_pkg::ll_word_t        push_d_o,
   output link_pkg::ll_rem_t         push_rem_o,
   output logic                      push_last_o,
   output comp_pkg::op_flags_t       flags_o,
   output comp_pkg::byte_len_t       src_len_o,
   output comp_pkg::task_idx_t       task_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_HEADER,
      ST_PAYLOAD,
      ST_WAIT_DONE
   } state_t;

   state_t             state;
   link_pkg::hdr_cnt_t hdr_cnt;
   logic               xfer;
   logic               last;

   // hold off the source while the FIFO is full or the RX side still runs
   assign tx_dst_rdy_n_o = fifo_full_i || (state == ST_WAIT_DONE);
   assign xfer           = !tx_src_rdy_n_i && !tx_dst_rdy_n_o;
   assign last           = !tx_eop_n_i || !tx_eof_n_i;

   assign push_o      = xfer && (state == ST_PAYLOAD);
   assign push_last_o = last;
   assign push_rem_o  = last ? tx_rem_i : 4'b0000;
   assign push_d_o    = last ? (tx_d_i & link_pkg::rem_mask(tx_rem_i)) : tx_d_i;

   always_ff @(posedge clk) begin
      if (!rst_n || eng_clear_i) begin
         state   <= ST_IDLE;
         hdr_cnt <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               // SOF word is header word 0, nothing in it is kept
               if (xfer && !tx_sof_n_i) begin
                  hdr_cnt <= 3'd1;
                  state   <= ST_HEADER;
               end
            end
            ST_HEADER: begin
               if (xfer) begin
                  hdr_cnt <= hdr_cnt + 3'd1;
                  if (hdr_cnt == link_pkg::HDR_LAST) begin
                     state <= ST_PAYLOAD;
                  end
               end
            end
            ST_PAYLOAD: begin
               if (xfer && last) begin
                  state <= ST_WAIT_DONE;
               end
            end
            default: begin
               if (frame_done_i) begin
                  state <= ST_IDLE;
               end
            end
         endcase
      end
   end

   // header fields
   always_ff @(posedge clk) begin
      if (state == ST_HEADER && xfer) begin
         if (hdr_cnt == link_pkg::HDR_FLAG_IDX) begin
            flags_o <= tx_d_i[31:29];
         end
         if (hdr_cnt == link_pkg::HDR_LEN_IDX) begin
            src_len_o <= tx_d_i;
         end
         if (hdr_cnt == link_pkg::HDR_TASK_IDX) begin
            task_o <= tx_d_i[9:0];
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/copy_channel.sv
`timescale 1ns/1ps
`default_nettype none

module copy_channel #(
   parameter int FIFO_DEPTH = 8
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 eng_clear_i,
   input  wire logic                 push_i,
   input  wire link_pkg::ll_word_t   push_d_i,
   input  wire link_pkg::ll_rem_t    push_rem_i,
   input  wire logic                 push_last_i,
   input  wire logic                 pop_i,
   output link_pkg::ll_word_t        head_d_o,
   output link_pkg::ll_rem_t         head_rem_o,
   output logic                      head_last_o,
   output logic                      empty_o,
   output logic                      full_o
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   link_pkg::ll_word_t mem_d    [FIFO_DEPTH];
   link_pkg::ll_rem_t  mem_rem  [FIFO_DEPTH];
   logic               mem_last [FIFO_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign empty_o = (count == '0);
   assign full_o  = (count == CNT_W'(FIFO_DEPTH));
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   assign head_d_o    = mem_d[rd_ptr];
   assign head_rem_o  = mem_rem[rd_ptr];
   assign head_last_o = mem_last[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem_d[wr_ptr]    <= push_d_i;
         mem_rem[wr_ptr]  <= push_rem_i;
         mem_last[wr_ptr] <= push_last_i;
      end
   end

   // pointers wrap at the depth, which need not be a power of two
   always_ff @(posedge clk) begin
      if (!rst_n || eng_clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/ll_rx_framer.sv
`timescale 1ns/1ps
`default_nettype none

module ll_rx_framer (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 eng_clear_i,
   input  wire link_pkg::ll_word_t   head_d_i,
   input  wire link_pkg::ll_rem_t    head_rem_i,
   input  wire logic                 head_last_i,
   input  wire logic                 empty_i,
   output logic                      pop_o,
   input  wire comp_pkg::op_flags_t  flags_i,
   input  wire comp_pkg::byte_len_t  src_len_i,
   input  wire comp_pkg::task_idx_t  task_i,
   output link_pkg::ll_word_t        rx_d_o,
   output link_pkg::ll_rem_t         rx_rem_o,
   output logic                      rx_sof_n_o,
   output logic                      rx_sop_n_o,
   output logic                      rx_eop_n_o,
   output logic                      rx_eof_n_o,
   output logic                      rx_src_rdy_n_o,
   input  wire logic                 rx_dst_rdy_n_i,
   output comp_pkg::byte_len_t       byte_count_o,
   output logic                      frame_done_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_PAYLOAD,
      ST_TRAILER
   } state_t;

   state_t             state;
   link_pkg::hdr_cnt_t trl_cnt;
   link_pkg::ll_word_t trl_word;
   logic               payload_vld;
   logic               first;
   logic               status;
   logic               xfer;

   // head of the FIFO drives the link directly, it only moves on a pop
   assign payload_vld = (state == ST_PAYLOAD) && !empty_i;
   // every word adds at least one byte, so a zero count marks the first word
   assign first       = (byte_count_o == '0);
   assign status      = (byte_count_o == src_len_i);
   assign xfer        = !rx_src_rdy_n_o && !rx_dst_rdy_n_i;

   always_comb begin
      case (trl_cnt)
         link_pkg::HDR_FLAG_IDX: trl_word = {flags_i, status, 28'h0};
         link_pkg::HDR_LEN_IDX:  trl_word = byte_count_o;
         link_pkg::HDR_TASK_IDX: trl_word = {22'h0, task_i};
         default:                trl_word = '0;
      endcase
   end

   assign rx_src_rdy_n_o = !(payload_vld || (state == ST_TRAILER));
   assign rx_sof_n_o     = !(payload_vld && first);
   assign rx_sop_n_o     = rx_sof_n_o;
   assign rx_eop_n_o     = !(payload_vld && head_last_i);
   assign rx_eof_n_o     = !((state == ST_TRAILER) && (trl_cnt == link_pkg::HDR_LAST));
   assign rx_d_o         = (state == ST_TRAILER) ? trl_word : head_d_i;
   assign rx_rem_o       = (payload_vld && head_last_i) ? head_rem_i : 4'b0000;

   assign pop_o        = xfer && (state == ST_PAYLOAD);
   assign frame_done_o = xfer && !rx_eof_n_o;

   always_ff @(posedge clk) begin
      if (!rst_n || eng_clear_i) begin
         state        <= ST_IDLE;
         trl_cnt      <= '0;
         byte_count_o <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (!empty_i) begin
                  byte_count_o <= '0;
                  state        <= ST_PAYLOAD;
               end
            end
            ST_PAYLOAD: begin
               if (xfer) begin
                  if (head_last_i) begin
                     byte_count_o <= byte_count_o +
                                     comp_pkg::byte_len_t'(link_pkg::rem_bytes(head_rem_i));
                     trl_cnt      <= '0;
                     state        <= ST_TRAILER;
                  end else begin
                     byte_count_o <= byte_count_o + 32'd4;
                  end
               end
            end
            default: begin
               if (xfer) begin
                  trl_cnt <= trl_cnt + 3'd1;
                  if (trl_cnt == link_pkg::HDR_LAST) begin
                     state <= ST_IDLE;
                  end
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/dcr_status.sv
`timescale 1ns/1ps
`default_nettype none

module dcr_status (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire comp_pkg::dcr_addr_t  dcr_abus_i,
   input  wire logic [31:0]          dcr_dbus_i,
   input  wire logic                 dcr_read_i,
   input  wire logic                 dcr_write_i,
   output logic                      dcr_ack_o,
   output logic [31:0]               dcr_dbus_o,
   input  wire comp_pkg::op_flags_t  flags_i,
   input  wire comp_pkg::task_idx_t  task_i,
   input  wire comp_pkg::byte_len_t  src_len_i,
   input  wire comp_pkg::byte_len_t  byte_count_i,
   output logic                      eng_clear_o
);

   logic [31:0] rd_data;

   always_comb begin
      case (dcr_abus_i)
         comp_pkg::DCR_TASK:  rd_data = {flags_i, 19'h0, task_i};
         comp_pkg::DCR_COUNT: rd_data = byte_count_i;
         comp_pkg::DCR_LEN:   rd_data = src_len_i;
         comp_pkg::DCR_ID0:   rd_data = comp_pkg::ID0_VALUE;
         comp_pkg::DCR_ID1:   rd_data = comp_pkg::ID1_VALUE;
         default:             rd_data = '0;
      endcase
   end

   // read data lines up with the ack
   always_ff @(posedge clk) begin
      dcr_dbus_o <= rd_data;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dcr_ack_o   <= 1'b0;
         eng_clear_o <= 1'b0;
      end else begin
         dcr_ack_o   <= dcr_read_i || dcr_write_i;
         eng_clear_o <= dcr_write_i && (dcr_abus_i == comp_pkg::DCR_CTRL) &&
                        dcr_dbus_i[comp_pkg::CTRL_CLEAR_BIT];
      end
   end

endmodule

`default_nettype wire

//--- hw/comp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module comp_unit #(
   parameter int FIFO_DEPTH = 8
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   // TX link
   input  wire link_pkg::ll_word_t   tx_d_i,
   input  wire link_pkg::ll_rem_t    tx_rem_i,
   input  wire logic                 tx_sof_n_i,
   input  wire logic                 tx_eop_n_i,
   input  wire logic                 tx_eof_n_i,
   input  wire logic                 tx_src_rdy_n_i,
   output logic                      tx_dst_rdy_n_o,
   // RX link
   output link_pkg::ll_word_t        rx_d_o,
   output link_pkg::ll_rem_t         rx_rem_o,
   output logic                      rx_sof_n_o,
   output logic                      rx_sop_n_o,
   output logic                      rx_eop_n_o,
   output logic                      rx_eof_n_o,
   output logic                      rx_src_rdy_n_o,
   input  wire logic                 rx_dst_rdy_n_i,
   // DCR
   input  wire comp_pkg::dcr_addr_t  dcr_abus_i,
   input  wire logic [31:0]          dcr_dbus_i,
   input  wire logic                 dcr_read_i,
   input  wire logic                 dcr_write_i,
   output logic                      dcr_ack_o,
   output logic [31:0]               dcr_dbus_o
);

   logic                eng_clear;
   logic                push;
   link_pkg::ll_word_t  push_d;
   link_pkg::ll_rem_t   push_rem;
   logic                push_last;
   logic                pop;
   link_pkg::ll_word_t  head_d;
   link_pkg::ll_rem_t   head_rem;
   logic                head_last;
   logic                fifo_empty;
   logic                fifo_full;
   logic                frame_done;
   comp_pkg::op_flags_t flags;
   comp_pkg::byte_len_t src_len;
   comp_pkg::task_idx_t task_idx;
   comp_pkg::byte_len_t byte_count;

   ll_tx_parser u_parser (
      .clk            (clk),
      .rst_n          (rst_n),
      .eng_clear_i    (eng_clear),
      .tx_d_i         (tx_d_i),
      .tx_rem_i       (tx_rem_i),
      .tx_sof_n_i     (tx_sof_n_i),
      .tx_eop_n_i     (tx_eop_n_i),
      .tx_eof_n_i     (tx_eof_n_i),
      .tx_src_rdy_n_i (tx_src_rdy_n_i),
      .tx_dst_rdy_n_o (tx_dst_rdy_n_o),
      .fifo_full_i    (fifo_full),
      .frame_done_i   (frame_done),
      .push_o         (push),
      .push_d_o       (push_d),
      .push_rem_o     (push_rem),
      .push_last_o    (push_last),
      .flags_o        (flags),
      .src_len_o      (src_len),
      .task_o         (task_idx)
   );

   copy_channel #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_channel (
      .clk         (clk),
      .rst_n       (rst_n),
      .eng_clear_i (eng_clear),
      .push_i      (push),
      .push_d_i    (push_d),
      .push_rem_i  (push_rem),
      .push_last_i (push_last),
      .pop_i       (pop),
      .head_d_o    (head_d),
      .head_rem_o  (head_rem),
      .head_last_o (head_last),
      .empty_o     (fifo_empty),
      .full_o      (fifo_full)
   );

   ll_rx_framer u_framer (
      .clk            (clk),
      .rst_n          (rst_n),
      .eng_clear_i    (eng_clear),
      .head_d_i       (head_d),
      .head_rem_i     (head_rem),
      .head_last_i    (head_last),
      .empty_i        (fifo_empty),
      .pop_o          (pop),
      .flags_i        (flags),
      .src_len_i      (src_len),
      .task_i         (task_idx),
      .rx_d_o         (rx_d_o),
      .rx_rem_o       (rx_rem_o),
      .rx_sof_n_o     (rx_sof_n_o),
      .rx_sop_n_o     (rx_sop_n_o),
      .rx_eop_n_o     (rx_eop_n_o),
      .rx_eof_n_o     (rx_eof_n_o),
      .rx_src_rdy_n_o (rx_src_rdy_n_o),
      .rx_dst_rdy_n_i (rx_dst_rdy_n_i),
      .byte_count_o   (byte_count),
      .frame_done_o   (frame_done)
   );

   dcr_status u_dcr (
      .clk          (clk),
      .rst_n        (rst_n),
      .dcr_abus_i   (dcr_abus_i),
      .dcr_dbus_i   (dcr_dbus_i),
      .dcr_read_i   (dcr_read_i),
      .dcr_write_i  (dcr_write_i),
      .dcr_ack_o    (dcr_ack_o),
      .dcr_dbus_o   (dcr_dbus_o),
      .flags_i      (flags),
      .task_i       (task_idx),
      .src_len_i    (src_len),
      .byte_count_i (byte_count),
      .eng_clear_o  (eng_clear)
   );

endmodule

`default_nettype wire

//--- sim/comp_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module comp_unit_assertions (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire logic                eng_clear_i,
   input  wire link_pkg::ll_word_t  rx_d_i,
   input  wire link_pkg::ll_rem_t   rx_rem_i,
   input  wire logic                rx_sof_n_i,
   input  wire logic                rx_sop_n_i,
   input  wire logic                rx_eop_n_i,
   input  wire logic                rx_eof_n_i,
   input  wire logic                rx_src_rdy_n_i,
   input  wire logic                rx_dst_rdy_n_i,
   input  wire logic                dcr_read_i,
   input  wire logic                dcr_write_i,
   input  wire logic                dcr_ack_i
);

   int unsigned stable_fails = 0;
   int unsigned ack_fails    = 0;
   int unsigned eof_fails    = 0;
   int unsigned reset_fails  = 0;

   // a clear may drop a stalled word
   rx_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (!rx_src_rdy_n_i && rx_dst_rdy_n_i && !eng_clear_i) |=>
         $stable({rx_d_i, rx_rem_i, rx_sof_n_i, rx_sop_n_i, rx_eop_n_i, rx_eof_n_i,
                  rx_src_rdy_n_i}))
      else begin
         stable_fails = stable_fails + 1;
         $error("rx strobes changed under back-pressure");
      end

   dcr_ack_timing: assert property (@(posedge clk) disable iff (!rst_n)
      dcr_ack_i == $past(dcr_read_i || dcr_write_i))
      else begin
         ack_fails = ack_fails + 1;
         $error("dcr ack not one cycle after the strobe");
      end

   rx_eof_valid: assert property (@(posedge clk) disable iff (!rst_n)
      !rx_eof_n_i |-> !rx_src_rdy_n_i)
      else begin
         eof_fails = eof_fails + 1;
         $error("rx eof without source ready");
      end

   rx_idle_after_reset: assert property (@(posedge clk) !rst_n |=> rx_src_rdy_n_i)
      else begin
         reset_fails = reset_fails + 1;
         $error("rx source ready low after reset");
      end

endmodule

`default_nettype wire

//--- sim/tb_comp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_comp_unit;

   localparam int          FIFO_DEPTH  = 8;
   localparam int          NUM_ROWS    = 8;
   localparam int          ABORT_WORDS = 3;
   localparam logic [31:0] LFSR_SEED   = 32'h0e87_a352;

   typedef struct packed {
      logic [7:0]  n_words;
      logic [3:0]  last_rem;
      logic [2:0]  flags;
      logic [9:0]  task_id;
      logic [31:0] src_len;
      logic        bp;
      logic        abort;
   } frame_row_t;

   logic                clk;
   logic                rst_n;
   link_pkg::ll_word_t  tx_d;
   link_pkg::ll_rem_t   tx_rem;
   logic                tx_sof_n;
   logic                tx_eop_n;
   logic                tx_eof_n;
   logic                tx_src_rdy_n;
   logic                tx_dst_rdy_n;
   link_pkg::ll_word_t  rx_d;
   link_pkg::ll_rem_t   rx_rem;
   logic                rx_sof_n;
   logic                rx_sop_n;
   logic                rx_eop_n;
   logic                rx_eof_n;
   logic                rx_src_rdy_n;
   logic                rx_dst_rdy_n;
   comp_pkg::dcr_addr_t dcr_abus;
   logic [31:0]         dcr_dbus_in;
   logic                dcr_read;
   logic                dcr_write;
   logic                dcr_ack;
   logic [31:0]         dcr_dbus_out;

   logic [31:0] lfsr;
   logic        bp_on;
   logic        rx_hold;
   logic        tx_stall;
   logic        eof_seen;
   int          checks;
   int          errors;
   logic [31:0] payload [$];
   logic [31:0] rx_data_q [$];
   logic [7:0]  rx_ctl_q [$];

   comp_unit #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_comp_unit (
      .clk            (clk),
      .rst_n          (rst_n),
      .tx_d_i         (tx_d),
      .tx_rem_i       (tx_rem),
      .tx_sof_n_i     (tx_sof_n),
      .tx_eop_n_i     (tx_eop_n),
      .tx_eof_n_i     (tx_eof_n),
      .tx_src_rdy_n_i (tx_src_rdy_n),
      .tx_dst_rdy_n_o (tx_dst_rdy_n),
      .rx_d_o         (rx_d),
      .rx_rem_o       (rx_rem),
      .rx_sof_n_o     (rx_sof_n),
      .rx_sop_n_o     (rx_sop_n),
      .rx_eop_n_o     (rx_eop_n),
      .rx_eof_n_o     (rx_eof_n),
      .rx_src_rdy_n_o (rx_src_rdy_n),
      .rx_dst_rdy_n_i (rx_dst_rdy_n),
      .dcr_abus_i     (dcr_abus),
      .dcr_dbus_i     (dcr_dbus_in),
      .dcr_read_i     (dcr_read),
      .dcr_write_i    (dcr_write),
      .dcr_ack_o      (dcr_ack),
      .dcr_dbus_o     (dcr_dbus_out)
   );

   bind comp_unit comp_unit_assertions u_assertions (
      .clk            (clk),
      .rst_n          (rst_n),
      .eng_clear_i    (eng_clear),
      .rx_d_i         (rx_d_o),
      .rx_rem_i       (rx_rem_o),
      .rx_sof_n_i     (rx_sof_n_o),
      .rx_sop_n_i     (rx_sop_n_o),
      .rx_eop_n_i     (rx_eop_n_o),
      .rx_eof_n_i     (rx_eof_n_o),
      .rx_src_rdy_n_i (rx_src_rdy_n_o),
      .rx_dst_rdy_n_i (rx_dst_rdy_n_i),
      .dcr_read_i     (dcr_read_i),
      .dcr_write_i    (dcr_write_i),
      .dcr_ack_i      (dcr_ack_o)
   );

   // words, last rem, flags, task, src_len, back-pressure, abort
   function automatic frame_row_t table_row(input int i);
      frame_row_t r;
      case (i)
         0:       r = '{8'd4,  4'b0000, 3'b101, 10'h012, 32'd16, 1'b0, 1'b0};
         1:       r = '{8'd1,  4'b0111, 3'b010, 10'h3ff, 32'd1,  1'b0, 1'b0};
         2:       r = '{8'd12, 4'b0011, 3'b111, 10'h155, 32'd46, 1'b1, 1'b0};
         3:       r = '{8'd6,  4'b0001, 3'b000, 10'h0a0, 32'd99, 1'b1, 1'b0};
         4:       r = '{8'd5,  4'b0000, 3'b011, 10'h2aa, 32'd20, 1'b0, 1'b1};
         5:       r = '{8'd20, 4'b0111, 3'b110, 10'h001, 32'd77, 1'b1, 1'b0};
         6:       r = '{8'd9,  4'b0011, 3'b100, 10'h200, 32'd34, 1'b0, 1'b0};
         default: r = '{8'd2,  4'b0001, 3'b001, 10'h07f, 32'd7,  1'b1, 1'b0};
      endcase
      return r;
   endfunction

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         bits = {bits[30:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
      return bits;
   endfunction

   // each set rem bit removes one low byte
   function automatic int valid_bytes(input logic [3:0] rem);
      return 4 - $countones(rem);
   endfunction

   function automatic logic [31:0] keep_mask(input logic [3:0] rem);
      return 32'hffff_ffff << (8 * (4 - valid_bytes(rem)));
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("** Error at %0t ns: %s: expected %h, got %h",
                  $time, what, expected, actual);
      end
   endtask

   task automatic send_word(input logic [31:0] word, input logic [3:0] rem,
                            input logic sof_n, input logic last_n);
      logic moved;
      moved    = 1'b0;
      tx_d     = word;
      tx_rem   = rem;
      tx_sof_n = sof_n;
      tx_eop_n = last_n;
      tx_eof_n = last_n;
      while (!moved) begin
         tx_src_rdy_n = tx_stall;
         @(negedge clk);
         moved = !tx_src_rdy_n && !tx_dst_rdy_n;
         @(posedge clk);
         #1;
      end
   endtask

   task automatic idle_tx();
      tx_src_rdy_n = 1'b1;
      tx_sof_n     = 1'b1;
      tx_eop_n     = 1'b1;
      tx_eof_n     = 1'b1;
   endtask

   // header fields sit among random filler bits
   task automatic send_frame(input frame_row_t row, input int n_send);
      logic [31:0] word;
      for (int k = 0; k < link_pkg::HDR_WORDS; k++) begin
         word = take_bits(32);
         if (k == int'(link_pkg::HDR_FLAG_IDX)) word[31:29] = row.flags;
         if (k == int'(link_pkg::HDR_LEN_IDX)) word = row.src_len;
         if (k == int'(link_pkg::HDR_TASK_IDX)) word[9:0] = row.task_id;
         send_word(word, 4'b0000, k != 0, 1'b1);
      end
      for (int k = 0; k < n_send; k++) begin
         if (k == int'(row.n_words) - 1) begin
            send_word(payload[k], row.last_rem, 1'b1, 1'b0);
         end else begin
            send_word(payload[k], 4'b0000, 1'b1, 1'b1);
         end
      end
   endtask

   task automatic dcr_access(input comp_pkg::dcr_addr_t addr, input logic wr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      dcr_abus    = addr;
      dcr_dbus_in = wdata;
      dcr_write   = wr;
      dcr_read    = !wr;
      @(negedge clk);
      check_value("dcr ack before strobe edge", 32'h0, 32'(dcr_ack));
      @(posedge clk);
      #1;
      dcr_read  = 1'b0;
      dcr_write = 1'b0;
      @(negedge clk);
      check_value("dcr ack one cycle after strobe", 32'h1, 32'(dcr_ack));
      rdata = dcr_dbus_out;
      @(posedge clk);
      #1;
   endtask

   task automatic dcr_expect(input comp_pkg::dcr_addr_t addr, input logic [31:0] expected,
                             input string what);
      logic [31:0] rdata;
      dcr_access(addr, 1'b0, 32'h0, rdata);
      check_value(what, expected, rdata);
   endtask

   task automatic check_frame(input frame_row_t row);
      int          n;
      int          j;
      logic [31:0] count;
      logic        status;
      logic [31:0] exp_d;
      logic [7:0]  exp_c;
      n      = int'(row.n_words);
      count  = 32'(4 * (n - 1) + valid_bytes(row.last_rem));
      status = (count == row.src_len);
      check_value("rx word count", 32'(n + 2 * link_pkg::HDR_WORDS),
                  32'(rx_data_q.size() + link_pkg::HDR_WORDS));
      for (int i = 0; i < rx_data_q.size() && i < n + link_pkg::HDR_WORDS; i++) begin
         // strobe byte is rem, sof_n, sop_n, eop_n, eof_n
         if (i < n) begin
            exp_d = payload[i];
            exp_c = 8'b0000_1111;
            if (i == 0) exp_c[3:2] = 2'b00;
            if (i == n - 1) begin
               exp_d      = payload[i] & keep_mask(row.last_rem);
               exp_c[7:4] = row.last_rem;
               exp_c[1]   = 1'b0;
            end
         end else begin
            j     = i - n;
            exp_c = {4'b0000, 3'b111, j != link_pkg::HDR_WORDS - 1};
            case (j)
               4:       exp_d = {row.flags, status, 28'h0};
               5:       exp_d = count;
               6:       exp_d = {22'h0, row.task_id};
               default: exp_d = 32'h0;
            endcase
         end
         check_value($sformatf("rx data word %0d", i), exp_d, rx_data_q[i]);
         check_value($sformatf("rx strobes word %0d", i), 32'(exp_c), 32'(rx_ctl_q[i]));
      end
      dcr_expect(comp_pkg::DCR_TASK, {row.flags, 19'h0, row.task_id}, "dcr task register");
      dcr_expect(comp_pkg::DCR_LEN, row.src_len, "dcr length register");
      dcr_expect(comp_pkg::DCR_COUNT, count, "dcr count register");
      dcr_expect(comp_pkg::DCR_ID0, comp_pkg::ID0_VALUE, "dcr id0 register");
      dcr_expect(comp_pkg::DCR_ID1, comp_pkg::ID1_VALUE, "dcr id1 register");
      dcr_expect(10'd3, 32'h0, "dcr unmapped address");
   endtask

   // rx held off so nothing of the frame leaves before the clear
   task automatic run_abort(input frame_row_t row);
      logic [31:0] rdata;
      rx_hold = 1'b1;
      send_frame(row, ABORT_WORDS);
      idle_tx();
      check_value("rx word held before clear", 32'h0, 32'(rx_src_rdy_n));
      dcr_access(comp_pkg::DCR_CTRL, 1'b1, 32'h8000_0000, rdata);
      repeat (3) @(posedge clk);
      #1;
      check_value("rx idle after clear", 32'h1, 32'(rx_src_rdy_n));
      check_value("tx ready after clear", 32'h0, 32'(tx_dst_rdy_n));
      rx_hold = 1'b0;
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // stall bits picked on the edge, applied 1 ns later
   initial begin
      logic [31:0] bits;
      forever begin
         @(posedge clk);
         bits     = bp_on ? take_bits(4) : 32'h0;
         tx_stall = bits[3];
         // rx stalls far more than tx so the FIFO runs full
         bits[0]  = (|bits[2:0]) || rx_hold;
         #1;
         rx_dst_rdy_n = bits[0];
      end
   end

   always @(negedge clk) begin
      if (rst_n && !rx_src_rdy_n && !rx_dst_rdy_n) begin
         rx_data_q.push_back(rx_d);
         rx_ctl_q.push_back({rx_rem, rx_sof_n, rx_sop_n, rx_eop_n, rx_eof_n});
         if (!rx_eof_n) eof_seen = 1'b1;
      end
   end

   initial begin
      frame_row_t r;
      int         limit;
      limit = 0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         r     = table_row(i);
         limit = limit + int'(r.n_words) + 2 * link_pkg::HDR_WORDS;
      end
      limit = limit * 50;
      repeat (limit) @(posedge clk);
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
   end

   initial begin
      frame_row_t row;
      int         assert_fails;
      lfsr         = LFSR_SEED;
      checks       = 0;
      errors       = 0;
      bp_on        = 1'b0;
      rx_hold      = 1'b0;
      tx_stall     = 1'b0;
      eof_seen     = 1'b0;
      rst_n        = 1'b0;
      tx_d         = '0;
      tx_rem       = '0;
      tx_sof_n     = 1'b1;
      tx_eop_n     = 1'b1;
      tx_eof_n     = 1'b1;
      tx_src_rdy_n = 1'b1;
      rx_dst_rdy_n = 1'b0;
      dcr_abus     = '0;
      dcr_dbus_in  = '0;
      dcr_read     = 1'b0;
      dcr_write    = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_value("tx ready after reset", 32'h0, 32'(tx_dst_rdy_n));
      check_value("rx strobes after reset", 32'h1f,
                  32'({rx_sof_n, rx_sop_n, rx_eop_n, rx_eof_n, rx_src_rdy_n}));
      check_value("dcr ack after reset", 32'h0, 32'(dcr_ack));
      for (int i = 0; i < NUM_ROWS; i++) begin
         row   = table_row(i);
         bp_on = row.bp;
         payload.delete();
         rx_data_q.delete();
         rx_ctl_q.delete();
         eof_seen = 1'b0;
         for (int k = 0; k < int'(row.n_words); k++) begin
            payload.push_back(take_bits(32));
         end
         if (row.abort) begin
            run_abort(row);
         end else begin
            send_frame(row, int'(row.n_words));
            idle_tx();
            wait (eof_seen == 1'b1);
            @(posedge clk);
            #1;
            check_frame(row);
         end
      end
      repeat (2) @(posedge clk);
      assert_fails = int'(u_comp_unit.u_assertions.stable_fails) +
                     int'(u_comp_unit.u_assertions.ack_fails) +
                     int'(u_comp_unit.u_assertions.eof_fails) +
                     int'(u_comp_unit.u_assertions.reset_fails);
      $display("checks: %0d, check errors: %0d, assertion failures: %0d",
               checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
hw/link_pkg.sv
hw/comp_pkg.sv
hw/ll_tx_parser.sv
hw/copy_channel.sv
hw/ll_rx_framer.sv
hw/dcr_status.sv
hw/comp_unit.sv
sim/comp_unit_assertions.sv
sim/tb_comp_unit.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_comp_unit \
   -o tb_comp_unit || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/tb_comp_unit +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "Test passed" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
